/* Makefile */
# Verilator build and run for the RV pipeline testbench

VERILATOR ?= verilator
TOP       ?= tb_rv_pipe
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qF "*** TEST FAILED ***" $(LOG); then \
		echo "Simulation reported failure"; exit 1; \
	fi
	@if ! grep -qF "*** TEST PASSED ***" $(LOG); then \
		echo "Simulation ended without a pass result"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* design/decode_stage.sv */
// Decode stage and register file
`timescale 1ns/10ps
`default_nettype none

module decode_stage import rv_pipe_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  ifid_t      ifid,
    input  rf_wr_t     rf_wr,
    input  logic       idex_flush,
    output logic [4:0] d_rs1,
    output logic [4:0] d_rs2,
    output idex_t      idex
);

    logic [XLEN-1:0] regs [32];
    logic [XLEN-1:0] insn;
    opcode_e         opcode;
    logic            use_rs1;
    logic            use_rs2;
    idex_t           dec;

    assign insn   = ifid.insn;
    assign opcode = opcode_e'(insn[6:0]);

    // Register file write port
    // x0 writes are already dropped in writeback
    always_ff @(posedge clk) begin
        if (rf_wr.wen) begin
            regs[rf_wr.rd] <= rf_wr.data;
        end
    end

    // ------------------------------------------------------------------------
    // Control and immediate decode
    // ------------------------------------------------------------------------
    always_comb begin
        dec         = '0;
        use_rs1     = 1'b0;
        use_rs2     = 1'b0;
        dec.valid   = ifid.valid;
        dec.pc      = ifid.pc;
        dec.opcode  = opcode;
        dec.alu_op  = ALU_ADD;
        case (opcode)
            OPCODE_RTYPE: begin
                use_rs1     = 1'b1;
                use_rs2     = 1'b1;
                dec.regwren = 1'b1;
                // funct7 bit 5 picks SUB over ADD
                dec.alu_op  = insn[30] ? ALU_SUB : ALU_ADD;
            end
            OPCODE_ITYPE: begin
                use_rs1     = 1'b1;
                dec.regwren = 1'b1;
                dec.imm     = {{20{insn[31]}}, insn[31:20]};
            end
            OPCODE_LOAD: begin
                use_rs1     = 1'b1;
                dec.regwren = 1'b1;
                dec.memren  = 1'b1;
                dec.imm     = {{20{insn[31]}}, insn[31:20]};
            end
            OPCODE_STORE: begin
                use_rs1     = 1'b1;
                use_rs2     = 1'b1;
                dec.memwren = 1'b1;
                dec.imm     = {{20{insn[31]}}, insn[31:25], insn[11:7]};
            end
            OPCODE_BRANCH: begin
                use_rs1       = 1'b1;
                use_rs2       = 1'b1;
                dec.is_branch = 1'b1;
                dec.alu_op    = ALU_SUB;
                dec.imm = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
            end
            OPCODE_JAL: begin
                dec.regwren = 1'b1;
                dec.is_jump = 1'b1;
                // ALU passes the link address through
                dec.alu_op  = ALU_PASS;
                dec.imm = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
            end
            default: begin
                // Unknown opcode retires with no side effects
            end
        endcase
        // Unused source fields read as x0 so they never raise a hazard
        dec.rs1     = (ifid.valid && use_rs1) ? insn[19:15] : 5'd0;
        dec.rs2     = (ifid.valid && use_rs2) ? insn[24:20] : 5'd0;
        dec.rd      = dec.regwren ? insn[11:7] : 5'd0;
        // No write-through, the hazard unit stalls instead
        dec.rs1_val = (dec.rs1 == 5'd0) ? '0 : regs[dec.rs1];
        dec.rs2_val = (dec.rs2 == 5'd0) ? '0 : regs[dec.rs2];
    end

    assign d_rs1 = dec.rs1;
    assign d_rs2 = dec.rs2;

    // ID/EX register, bubble on flush or on an empty IF/ID
    always_ff @(posedge clk) begin
        if (rst || idex_flush || !ifid.valid) begin
            idex <= '0;
        end else begin
            idex <= dec;
        end
    end

endmodule

`default_nettype wire

/* design/exec_mem_stage.sv */
// Execute and memory stages
`timescale 1ns/10ps
`default_nettype none

module exec_mem_stage import rv_pipe_pkg::*; #(
    parameter int DMEM_DEPTH = 64
) (
    input  logic            clk,
    input  logic            rst,
    input  idex_t           idex,
    input  fwd_sel_e        rs1_sel,
    input  fwd_sel_e        rs2_sel,
    input  logic            wm_fwd_sel,
    input  logic [XLEN-1:0] wb_data,
    output logic            e_br_taken,
    output logic            redirect_valid,
    output logic [XLEN-1:0] redirect_pc,
    output exmem_t          exmem,
    output memwb_t          memwb
);

    localparam int DA_W = $clog2(DMEM_DEPTH);

    logic [XLEN-1:0] dmem [DMEM_DEPTH];
    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] alu_b;
    logic [XLEN-1:0] alu_res;
    logic            use_imm;
    logic [DA_W-1:0] daddr;
    logic [XLEN-1:0] store_val;
    logic [XLEN-1:0] load_val;

    // Operand source mux, reserved select falls back to ID/EX
    function automatic logic [XLEN-1:0] pick_operand(
        input fwd_sel_e        sel,
        input logic [XLEN-1:0] id_val,
        input logic [XLEN-1:0] mem_val,
        input logic [XLEN-1:0] wb_val
    );
        case (sel)
            FWD_MEM: return mem_val;
            FWD_WB:  return wb_val;
            default: return id_val;
        endcase
    endfunction

    // ------------------------------------------------------------------------
    // Execute
    // ------------------------------------------------------------------------
    assign op_a = pick_operand(rs1_sel, idex.rs1_val, exmem.alu_res, wb_data);
    assign op_b = pick_operand(rs2_sel, idex.rs2_val, exmem.alu_res, wb_data);

    assign use_imm = (idex.opcode == OPCODE_ITYPE) || (idex.opcode == OPCODE_LOAD) ||
                     (idex.opcode == OPCODE_STORE);

    // JAL feeds its link address as the second operand
    assign alu_b = idex.is_jump ? (idex.pc + 32'd4) : (use_imm ? idex.imm : op_b);

    always_comb begin
        case (idex.alu_op)
            ALU_SUB:  alu_res = op_a - alu_b;
            ALU_PASS: alu_res = alu_b;
            default:  alu_res = op_a + alu_b;
        endcase
    end

    // BEQ subtracts, equal operands leave a zero result
    assign e_br_taken     = idex.valid && idex.is_branch && (alu_res == '0);
    assign redirect_valid = e_br_taken || (idex.valid && idex.is_jump);
    assign redirect_pc    = idex.pc + idex.imm;

    // EX/MEM register
    always_ff @(posedge clk) begin
        if (rst) begin
            exmem <= '0;
        end else begin
            exmem.valid      <= idex.valid;
            exmem.pc         <= idex.pc;
            exmem.rd         <= idex.rd;
            exmem.rs2        <= idex.rs2;
            exmem.alu_res    <= alu_res;
            exmem.store_data <= op_b;
            exmem.regwren    <= idex.regwren;
            exmem.memren     <= idex.memren;
            exmem.memwren    <= idex.memwren;
        end
    end

    // ------------------------------------------------------------------------
    // Memory
    // ------------------------------------------------------------------------
    assign daddr = exmem.alu_res[DA_W+1:2];

    // Store data may come from the load or ALU op now in WB
    assign store_val = wm_fwd_sel ? wb_data : exmem.store_data;

    always_ff @(posedge clk) begin
        if (exmem.valid && exmem.memwren) begin
            dmem[daddr] <= store_val;
        end
    end

    assign load_val = dmem[daddr];

    // MEM/WB register
    always_ff @(posedge clk) begin
        if (rst) begin
            memwb <= '0;
        end else begin
            memwb.valid     <= exmem.valid;
            memwb.pc        <= exmem.pc;
            memwb.rd        <= exmem.rd;
            memwb.regwren   <= exmem.regwren;
            memwb.memren    <= exmem.memren;
            memwb.alu_res   <= exmem.alu_res;
            memwb.load_data <= load_val;
        end
    end

endmodule

`default_nettype wire

/* design/hazard_unit.sv */
// Pipeline hazard control
`timescale 1ns/10ps
`default_nettype none

module hazard_unit import rv_pipe_pkg::*; (
    // Decode sources
    input  logic [4:0] d_rs1,
    input  logic [4:0] d_rs2,
    // Execute
    input  logic [4:0] e_rs1,
    input  logic [4:0] e_rs2,
    input  logic [4:0] e_rd,
    input  logic       e_memren,
    input  opcode_e    e_opcode,
    input  logic       e_br_taken,
    // Memory
    input  logic [4:0] m_rd,
    input  logic [4:0] m_rs2,
    input  logic       m_regwren,
    input  logic       m_memwren,
    // Writeback
    input  logic [4:0] w_rd,
    input  logic       w_regwren,
    // Stall and flush
    output logic       stall_if,
    output logic       ifid_wren,
    output logic       ifid_flush,
    output logic       idex_flush,
    // Forwarding selects
    output fwd_sel_e   rs1_sel,
    output fwd_sel_e   rs2_sel,
    output logic       wm_fwd_sel
);

    logic m_live;
    logic w_live;
    logic load_use;
    logic wd_hazard;
    logic stall_hazard;
    logic cf_change;

    // A result is live only when it targets a real register
    assign m_live = m_regwren && (m_rd != 5'd0);
    assign w_live = w_regwren && (w_rd != 5'd0);

    // ------------------------------------------------------------------------
    // Stalls
    // ------------------------------------------------------------------------
    // Load data is not ready for the instruction right behind it
    assign load_use = e_memren && (e_rd != 5'd0) && ((e_rd == d_rs1) || (e_rd == d_rs2));

    // WB writes at the clock edge, decode would read the stale value
    assign wd_hazard = w_live && ((w_rd == d_rs1) || (w_rd == d_rs2));

    assign stall_hazard = load_use || wd_hazard;

    // Taken BEQ or any JAL in EX
    assign cf_change = e_br_taken || (e_opcode == OPCODE_JAL);

    // Redirect wins, the stalled decode entry is on the wrong path anyway
    assign stall_if   = stall_hazard && !cf_change;
    assign ifid_wren  = !stall_if;
    assign ifid_flush = cf_change;
    // Bubble into EX for a stall as well as for a redirect
    assign idex_flush = cf_change || stall_hazard;

    // ------------------------------------------------------------------------
    // Forwarding
    // ------------------------------------------------------------------------
    // MEM holds the younger result so it is checked first
    assign rs1_sel = (m_live && (m_rd == e_rs1)) ? FWD_MEM :
                     (w_live && (w_rd == e_rs1)) ? FWD_WB  : FWD_NONE;
    assign rs2_sel = (m_live && (m_rd == e_rs2)) ? FWD_MEM :
                     (w_live && (w_rd == e_rs2)) ? FWD_WB  : FWD_NONE;

    // Store in MEM takes its data from the instruction in WB
    assign wm_fwd_sel = m_memwren && w_live && (w_rd == m_rs2);

endmodule

`default_nettype wire

/* design/insn_fetch.sv */
// Instruction fetch stage
`timescale 1ns/10ps
`default_nettype none

module insn_fetch import rv_pipe_pkg::*; #(
    parameter int IMEM_DEPTH = 64
) (
    input  logic            clk,
    input  logic            rst,
    input  prog_wr_t        prog,
    input  logic            go,
    input  logic            stall_if,
    input  logic            ifid_wren,
    input  logic            ifid_flush,
    input  logic            redirect_valid,
    input  logic [XLEN-1:0] redirect_pc,
    output ifid_t           ifid
);

    localparam int IA_W = $clog2(IMEM_DEPTH);

    logic [XLEN-1:0] imem [IMEM_DEPTH];
    logic            running;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] insn;

    // Program load port, word addressed
    always_ff @(posedge clk) begin
        if (prog.valid) begin
            imem[prog.addr[IA_W-1:0]] <= prog.insn;
        end
    end

    // Fetch idles until the go strobe, then runs for good
    always_ff @(posedge clk) begin
        if (rst) begin
            running <= 1'b0;
        end else if (go) begin
            running <= 1'b1;
        end
    end

    // Redirect beats a stall, PC stays at 0 until running
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else if (redirect_valid) begin
            pc <= redirect_pc;
        end else if (running && !stall_if) begin
            pc <= pc + 32'd4;
        end
    end

    assign insn = imem[pc[IA_W+1:2]];

    // IF/ID register
    // Flush makes a bubble, a low write enable holds the entry
    always_ff @(posedge clk) begin
        if (rst || ifid_flush) begin
            ifid <= '0;
        end else if (ifid_wren) begin
            ifid.valid <= running;
            ifid.pc    <= pc;
            ifid.insn  <= insn;
        end
    end

endmodule

`default_nettype wire

/* design/rv_pipe_pkg.sv */
// RV pipeline shared types
`default_nettype none

package rv_pipe_pkg;

    localparam int XLEN    = 32;
    // Word address width of the program load port
    localparam int PROG_AW = 12;

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        OPCODE_RTYPE  = 7'b0110011,
        OPCODE_ITYPE  = 7'b0010011,
        OPCODE_LOAD   = 7'b0000011,
        OPCODE_STORE  = 7'b0100011,
        OPCODE_BRANCH = 7'b1100011,
        OPCODE_JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [1:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_PASS
    } alu_op_e;

    // EX operand source, 2'b11 is reserved
    typedef enum logic [1:0] {
        FWD_NONE = 2'b00,
        FWD_MEM  = 2'b01,
        FWD_WB   = 2'b10
    } fwd_sel_e;

    // ------------------------------------------------------------------------
    // Port and stage records
    // ------------------------------------------------------------------------

    typedef struct packed {
        logic               valid;
        logic [PROG_AW-1:0] addr;
        logic [XLEN-1:0]    insn;
    } prog_wr_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] insn;
    } ifid_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic [4:0]      rs1;
        logic [4:0]      rs2;
        logic [4:0]      rd;
        logic [XLEN-1:0] rs1_val;
        logic [XLEN-1:0] rs2_val;
        logic [XLEN-1:0] imm;
        alu_op_e         alu_op;
        logic            regwren;
        logic            memren;
        logic            memwren;
        logic            is_branch;
        logic            is_jump;
        opcode_e         opcode;
    } idex_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic [4:0]      rd;
        logic [4:0]      rs2;
        logic [XLEN-1:0] alu_res;
        logic [XLEN-1:0] store_data;
        logic            regwren;
        logic            memren;
        logic            memwren;
    } exmem_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic [4:0]      rd;
        logic            regwren;
        logic            memren;
        logic [XLEN-1:0] alu_res;
        logic [XLEN-1:0] load_data;
    } memwb_t;

    typedef struct packed {
        logic            wen;
        logic [4:0]      rd;
        logic [XLEN-1:0] data;
    } rf_wr_t;

    // One record per completed instruction
    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic [4:0]      rd;
        logic            regwren;
        logic [XLEN-1:0] value;
    } retire_t;

endpackage

`default_nettype wire

/* design/rv_pipe_top.sv */
// Five stage RV pipeline top
`timescale 1ns/10ps
`default_nettype none

module rv_pipe_top import rv_pipe_pkg::*; #(
    parameter int IMEM_DEPTH = 64,
    parameter int DMEM_DEPTH = 64
) (
    input  logic     clk,
    input  logic     rst,
    input  prog_wr_t prog,
    input  logic     go,
    output retire_t  retire
);

    // Stage records
    ifid_t           ifid;
    idex_t           idex;
    exmem_t          exmem;
    memwb_t          memwb;
    rf_wr_t          rf_wr;
    logic [XLEN-1:0] wb_data;

    // Redirect from EX
    logic            e_br_taken;
    logic            redirect_valid;
    logic [XLEN-1:0] redirect_pc;

    // Hazard unit signals
    logic [4:0]      d_rs1;
    logic [4:0]      d_rs2;
    logic            stall_if;
    logic            ifid_wren;
    logic            ifid_flush;
    logic            idex_flush;
    fwd_sel_e        rs1_sel;
    fwd_sel_e        rs2_sel;
    logic            wm_fwd_sel;

    insn_fetch #(
        .IMEM_DEPTH(IMEM_DEPTH)
    ) u_fetch (
        .clk            (clk),
        .rst            (rst),
        .prog           (prog),
        .go             (go),
        .stall_if       (stall_if),
        .ifid_wren      (ifid_wren),
        .ifid_flush     (ifid_flush),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .ifid           (ifid)
    );

    decode_stage u_decode (
        .clk        (clk),
        .rst        (rst),
        .ifid       (ifid),
        .rf_wr      (rf_wr),
        .idex_flush (idex_flush),
        .d_rs1      (d_rs1),
        .d_rs2      (d_rs2),
        .idex       (idex)
    );

    exec_mem_stage #(
        .DMEM_DEPTH(DMEM_DEPTH)
    ) u_exec_mem (
        .clk            (clk),
        .rst            (rst),
        .idex           (idex),
        .rs1_sel        (rs1_sel),
        .rs2_sel        (rs2_sel),
        .wm_fwd_sel     (wm_fwd_sel),
        .wb_data        (wb_data),
        .e_br_taken     (e_br_taken),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .exmem          (exmem),
        .memwb          (memwb)
    );

    // Hazard inputs are taken straight from the stage registers
    hazard_unit u_hazard (
        .d_rs1      (d_rs1),
        .d_rs2      (d_rs2),
        .e_rs1      (idex.rs1),
        .e_rs2      (idex.rs2),
        .e_rd       (idex.rd),
        .e_memren   (idex.memren),
        .e_opcode   (idex.opcode),
        .e_br_taken (e_br_taken),
        .m_rd       (exmem.rd),
        .m_rs2      (exmem.rs2),
        .m_regwren  (exmem.regwren),
        .m_memwren  (exmem.memwren),
        .w_rd       (memwb.rd),
        .w_regwren  (memwb.regwren),
        .stall_if   (stall_if),
        .ifid_wren  (ifid_wren),
        .ifid_flush (ifid_flush),
        .idex_flush (idex_flush),
        .rs1_sel    (rs1_sel),
        .rs2_sel    (rs2_sel),
        .wm_fwd_sel (wm_fwd_sel)
    );

    writeback_retire u_wb (
        .memwb   (memwb),
        .rf_wr   (rf_wr),
        .wb_data (wb_data),
        .retire  (retire)
    );

endmodule

`default_nettype wire

/* design/writeback_retire.sv */
// Writeback and retire
`timescale 1ns/10ps
`default_nettype none

module writeback_retire import rv_pipe_pkg::*; (
    input  memwb_t          memwb,
    output rf_wr_t          rf_wr,
    output logic [XLEN-1:0] wb_data,
    output retire_t         retire
);

    // Load data or ALU result
    assign wb_data = memwb.memren ? memwb.load_data : memwb.alu_res;

    // Register file write, x0 stays zero
    assign rf_wr.wen  = memwb.valid && memwb.regwren && (memwb.rd != 5'd0);
    assign rf_wr.rd   = memwb.rd;
    assign rf_wr.data = wb_data;

    // One retire strobe per valid entry, bubbles never show
    assign retire.valid   = memwb.valid;
    assign retire.pc      = memwb.pc;
    assign retire.rd      = memwb.rd;
    assign retire.regwren = memwb.regwren;
    assign retire.value   = wb_data;

endmodule

`default_nettype wire

/* sources.f */
design/rv_pipe_pkg.sv
design/insn_fetch.sv
design/decode_stage.sv
design/exec_mem_stage.sv
design/hazard_unit.sv
design/writeback_retire.sv
design/rv_pipe_top.sv
tb/rv_pipe_chk.sv
tb/tb_rv_pipe.sv

/* tb/rv_pipe_chk.sv */
// Hazard control assertions
`timescale 1ns/10ps
`default_nettype none

module rv_pipe_chk import rv_pipe_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     stall_if,
    input  logic     ifid_flush,
    input  fwd_sel_e rs1_sel,
    input  fwd_sel_e rs2_sel,
    input  ifid_t    ifid,
    input  idex_t    idex,
    input  exmem_t   exmem,
    input  memwb_t   memwb
);

    // A stalled fetch keeps its IF/ID entry for the next cycle
    stall_holds_ifid: assert property (@(posedge clk) disable iff (rst)
        stall_if |=> $stable(ifid))
        else $error("IF/ID changed while fetch was stalled");

    // MEM forwarding only takes a result from a real instruction
    fwd_mem_valid: assert property (@(posedge clk) disable iff (rst)
        ((rs1_sel == FWD_MEM) || (rs2_sel == FWD_MEM)) |-> exmem.valid)
        else $error("Operand forwarded from a bubble in MEM");

    // Same for WB forwarding
    fwd_wb_valid: assert property (@(posedge clk) disable iff (rst)
        ((rs1_sel == FWD_WB) || (rs2_sel == FWD_WB)) |-> memwb.valid)
        else $error("Operand forwarded from a bubble in WB");

    // A redirect removes both younger entries
    flush_clears_young: assert property (@(posedge clk) disable iff (rst)
        ifid_flush |=> (!ifid.valid && !idex.valid))
        else $error("Wrong-path entry survived an IF/ID flush");

endmodule

// Hazard control and stage records as wired in the top level
bind rv_pipe_top rv_pipe_chk u_chk (
    .clk        (clk),
    .rst        (rst),
    .stall_if   (stall_if),
    .ifid_flush (ifid_flush),
    .rs1_sel    (rs1_sel),
    .rs2_sel    (rs2_sel),
    .ifid       (ifid),
    .idex       (idex),
    .exmem      (exmem),
    .memwb      (memwb)
);

`default_nettype wire

/* tb/tb_rv_pipe.sv */
// RV pipeline testbench
`timescale 1ns/10ps
`default_nettype none

module tb_rv_pipe import rv_pipe_pkg::*; ();

    localparam int IMEM_DEPTH = 64;
    localparam int DMEM_DEPTH = 64;
    localparam int PROG_LEN   = 48;
    localparam int NUM_TESTS  = 20;
    localparam int TIMEOUT    = 200;
    localparam int SEED       = 69506;

    logic     clk;
    logic     rst;
    prog_wr_t prog;
    logic     go;
    retire_t  retire;

    // Model state, data memory persists across programs as in the DUT
    logic [XLEN-1:0] prog_mem [IMEM_DEPTH];
    logic [XLEN-1:0] model_regs [8];
    logic [XLEN-1:0] model_mem [DMEM_DEPTH];
    bit              written [DMEM_DEPTH];
    int              written_q [$];
    retire_t         exp_q [$];

    int              total_errors;
    int              tests_failed;
    int unsigned     seed_ret;

    rv_pipe_top #(
        .IMEM_DEPTH(IMEM_DEPTH),
        .DMEM_DEPTH(DMEM_DEPTH)
    ) UUT (
        .clk    (clk),
        .rst    (rst),
        .prog   (prog),
        .go     (go),
        .retire (retire)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ------------------------------------------------------------------------
    // RV32I encoders
    // ------------------------------------------------------------------------
    function automatic logic [31:0] enc_rtype(input bit sub, input int rd, input int rs1,
                                              input int rs2);
        return {1'b0, sub, 5'b00000, 5'(rs2), 5'(rs1), 3'b000, 5'(rd), 7'b0110011};
    endfunction

    // ADDI and LW share this format
    function automatic logic [31:0] enc_itype(input logic [31:0] imm, input int rs1,
                                              input logic [2:0] funct3, input int rd,
                                              input logic [6:0] opc);
        return {imm[11:0], 5'(rs1), funct3, 5'(rd), opc};
    endfunction

    function automatic logic [31:0] enc_sw(input logic [31:0] imm, input int rs2, input int rs1);
        return {imm[11:5], 5'(rs2), 5'(rs1), 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] enc_beq(input logic [31:0] off, input int rs1, input int rs2);
        return {off[12], off[10:5], 5'(rs2), 5'(rs1), 3'b000, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] enc_jal(input logic [31:0] off, input int rd);
        return {off[20], off[10:1], off[11], off[19:12], 5'(rd), 7'b1101111};
    endfunction

    // ------------------------------------------------------------------------
    // Program generator and instruction-level model
    // ------------------------------------------------------------------------
    function automatic int pick_reg();
        return int'($urandom % 8);
    endfunction

    // Forward target, never past the terminal jump
    function automatic int pick_target(input int idx);
        int tgt;
        tgt = idx + 1 + int'($urandom % 5);
        return (tgt > PROG_LEN) ? PROG_LEN : tgt;
    endfunction

    task automatic expect_retire(input int idx, input int rd, input bit wren,
                                 input logic [31:0] value);
        retire_t rec;
        rec.valid   = 1'b1;
        rec.pc      = 32'(idx * 4);
        rec.rd      = 5'(rd);
        rec.regwren = wren;
        rec.value   = value;
        exp_q.push_back(rec);
    endtask

    // x0 stays zero
    task automatic set_reg(input int rd, input logic [31:0] value);
        if (rd != 0) begin
            model_regs[rd] = value;
        end
    endtask

    // Each index runs as it is generated
    // Control flow only goes forward, so the model pc is never behind
    task automatic build_program();
        int          pc_idx;
        int          next_idx;
        int          kind;
        int          rd;
        int          rs1;
        int          rs2;
        int          word;
        int          tgt;
        int          imm;
        bit          live;
        logic [31:0] val;
        pc_idx = 0;
        exp_q.delete();
        for (int i = 0; i < PROG_LEN; i++) begin
            live     = (i == pc_idx);
            next_idx = i + 1;
            rd       = pick_reg();
            rs1      = pick_reg();
            rs2      = pick_reg();
            kind     = int'($urandom % 16);
            // Prologue gives x1..x7 known values
            if (i < 7) begin
                kind = 4;
                rd   = i + 1;
                rs1  = 0;
            end
            // No load before some word holds a known value
            if (kind >= 7 && kind <= 9 && written_q.size() == 0) begin
                kind = 10;
            end
            if (kind <= 3) begin
                // ADD or SUB
                prog_mem[i] = enc_rtype(kind >= 2, rd, rs1, rs2);
                val = (kind >= 2) ? model_regs[rs1] - model_regs[rs2]
                                  : model_regs[rs1] + model_regs[rs2];
                if (live) begin
                    expect_retire(i, rd, 1'b1, val);
                    set_reg(rd, val);
                end
            end else if (kind <= 6) begin
                // ADDI
                imm         = int'($urandom % 4096) - 2048;
                prog_mem[i] = enc_itype(32'(imm), rs1, 3'b000, rd, 7'b0010011);
                val         = model_regs[rs1] + 32'(imm);
                if (live) begin
                    expect_retire(i, rd, 1'b1, val);
                    set_reg(rd, val);
                end
            end else if (kind <= 9) begin
                // LW from a word with a known value
                word        = written_q[$urandom % written_q.size()];
                prog_mem[i] = enc_itype(32'(word * 4), 0, 3'b010, rd, 7'b0000011);
                val         = model_mem[word];
                if (live) begin
                    expect_retire(i, rd, 1'b1, val);
                    set_reg(rd, val);
                end
            end else if (kind <= 12) begin
                // SW
                word        = int'($urandom % DMEM_DEPTH);
                prog_mem[i] = enc_sw(32'(word * 4), rs2, 0);
                if (live) begin
                    model_mem[word] = model_regs[rs2];
                    if (!written[word]) begin
                        written[word] = 1'b1;
                        written_q.push_back(word);
                    end
                    expect_retire(i, 0, 1'b0, '0);
                end
            end else if (kind <= 14) begin
                // BEQ, same register half the time so it is often taken
                if ($urandom % 2 == 0) begin
                    rs2 = rs1;
                end
                tgt         = pick_target(i);
                prog_mem[i] = enc_beq(32'((tgt - i) * 4), rs1, rs2);
                if (live) begin
                    expect_retire(i, 0, 1'b0, '0);
                    if (model_regs[rs1] == model_regs[rs2]) begin
                        next_idx = tgt;
                    end
                end
            end else begin
                // JAL with link
                tgt         = pick_target(i);
                prog_mem[i] = enc_jal(32'((tgt - i) * 4), rd);
                val         = 32'(i * 4 + 4);
                if (live) begin
                    expect_retire(i, rd, 1'b1, val);
                    set_reg(rd, val);
                    next_idx = tgt;
                end
            end
            if (live) begin
                pc_idx = next_idx;
            end
        end
        // Terminal jump to itself
        prog_mem[PROG_LEN] = enc_jal(32'd0, 0);
        expect_retire(PROG_LEN, 0, 1'b1, 32'(PROG_LEN * 4 + 4));
        // Rest of memory holds ADDI x0 with the word address
        for (int a = PROG_LEN + 1; a < IMEM_DEPTH; a++) begin
            prog_mem[a] = enc_itype(32'(a), 0, 3'b000, 0, 7'b0010011);
        end
    endtask

    // ------------------------------------------------------------------------
    // Stimulus and checking
    // ------------------------------------------------------------------------
    task automatic apply_reset();
        @(posedge clk);
        rst <= 1'b1;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
    endtask

    task automatic load_program();
        for (int a = 0; a < IMEM_DEPTH; a++) begin
            @(posedge clk);
            prog.valid <= 1'b1;
            prog.addr  <= PROG_AW'(a);
            prog.insn  <= prog_mem[a];
        end
        @(posedge clk);
        prog <= '0;
    endtask

    task automatic start_core();
        @(posedge clk);
        go <= 1'b1;
        @(posedge clk);
        go <= 1'b0;
    endtask

    // Retire is sampled at the falling edge, away from register updates
    task automatic check_retires(output int errs);
        retire_t exp;
        int      waited;
        bit      timed_out;
        errs      = 0;
        timed_out = 1'b0;
        while (!timed_out && exp_q.size() > 0) begin
            exp    = exp_q.pop_front();
            waited = 0;
            @(negedge clk);
            while (!retire.valid && waited < TIMEOUT) begin
                @(negedge clk);
                waited++;
            end
            if (!retire.valid) begin
                $display("Timeout: no instruction retired within %0d cycles, expected pc %h",
                         TIMEOUT, exp.pc);
                timed_out = 1'b1;
                errs++;
            end else if (retire.pc != exp.pc || retire.regwren != exp.regwren ||
                         retire.rd != exp.rd ||
                         (exp.regwren && retire.value != exp.value)) begin
                // Record fields shown as rd/wren/value
                $display("Mismatch at %0t: pc %h exp %0d/%0b/%h got pc %h %0d/%0b/%h",
                         $time, exp.pc, exp.rd, exp.regwren, exp.value,
                         retire.pc, retire.rd, retire.regwren, retire.value);
                errs++;
            end
        end
    endtask

    task automatic run_test(input int num);
        int errs;
        int n_exp;
        apply_reset();
        build_program();
        n_exp = exp_q.size();
        load_program();
        start_core();
        check_retires(errs);
        total_errors += errs;
        if (errs != 0) begin
            tests_failed++;
        end
        $display("Program %0d: %0d retires expected, %0d errors", num, n_exp, errs);
    endtask

    initial begin
        rst          = 1'b1;
        go           = 1'b0;
        prog         = '0;
        total_errors = 0;
        tests_failed = 0;
        seed_ret     = $urandom(SEED);
        for (int r = 0; r < 8; r++) begin
            model_regs[r] = '0;
        end
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end
        $display("Programs run %0d, failed %0d, total errors %0d",
                 NUM_TESTS, tests_failed, total_errors);
        if (total_errors == 0 && tests_failed == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire
